//--- mips_pkg.sv
package mips_pkg;

    // ------------------------------------------------------------
    // alu opcodes
    // ------------------------------------------------------------
    // add must stay at zero, a bubble in the stage is an all-zero word
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_addu = 4'd1,
        alu_sub  = 4'd2,
        alu_subu = 4'd3,
        alu_and  = 4'd4,
        alu_or   = 4'd5,
        alu_xor  = 4'd6,
        alu_nor  = 4'd7,
        alu_slt  = 4'd8,
        alu_sltu = 4'd9,
        alu_sll  = 4'd10,   // src1 << src0[4:0]
        alu_srl  = 4'd11,
        alu_sra  = 4'd12,
        alu_lui  = 4'd13    // src1[15:0] into the upper half
    } alu_op_e;

    // store kinds, st_none also zero for bubbles
    typedef enum logic [2:0] {
        st_none = 3'd0,
        st_b    = 3'd1,
        st_h    = 3'd2,
        st_w    = 3'd3,
        st_wl   = 3'd4,     // swl
        st_wr   = 3'd5      // swr
    } store_e;

    // address alignment required by a load or store
    typedef enum logic [1:0] {
        al_none = 2'd0,
        al_half = 2'd1,
        al_word = 2'd2
    } align_e;

    // cp0 exception codes
    localparam logic [4:0] exc_adel = 5'd4;   // load / fetch address error
    localparam logic [4:0] exc_ades = 5'd5;   // store address error
    localparam logic [4:0] exc_ov   = 5'd12;  // arithmetic overflow

    // ------------------------------------------------------------
    // stage boundary payloads
    // ------------------------------------------------------------
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] nnpc;
        logic [31:0] src0;
        logic [31:0] src1;
        logic [31:0] rt_data;   // store data before lane placement
        alu_op_e     aluop;
        store_e      store;
        align_e      align;
        logic        is_load;
        logic [4:0]  wnum;
        logic [4:0]  sel_wb;
        logic [4:0]  load_ext;  // consumed in mem / wb only
    } id_exe_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] nnpc;
        logic [31:0] alu_res;
        logic [4:0]  wnum;
        logic [4:0]  sel_wb;
        logic [4:0]  load_ext;
        logic [1:0]  byte_lane; // low address bits for the load aligner
        logic        exc;
        logic [4:0]  exc_code;
    } exe_mem_t;

endpackage

//--- alu.sv
`timescale 1ns/1ns

module alu import mips_pkg::*; (
    input  logic [31:0] src0,
    input  logic [31:0] src1,
    input  alu_op_e     op,
    output logic [31:0] result,
    output logic        overflow
);

    logic [31:0] sum;
    logic [31:0] diff;
    logic        sum_ov;
    logic        diff_ov;
    logic [4:0]  shamt;

    assign sum   = src0 + src1;
    assign diff  = src0 - src1;
    assign shamt = src0[4:0];   // shift amount comes from the first operand

    // signed overflow: operand signs vs result sign
    assign sum_ov  = (src0[31] == src1[31]) && (sum[31] != src0[31]);
    assign diff_ov = (src0[31] != src1[31]) && (diff[31] != src0[31]);

    // ------------------------------------------------------------
    // result select
    // ------------------------------------------------------------
    always_comb begin
        case (op)
            alu_add,
            alu_addu: result = sum;
            alu_sub,
            alu_subu: result = diff;
            alu_and:  result = src0 & src1;
            alu_or:   result = src0 | src1;
            alu_xor:  result = src0 ^ src1;
            alu_nor:  result = ~(src0 | src1);
            alu_slt:  result = {31'd0, $signed(src0) < $signed(src1)};
            alu_sltu: result = {31'd0, src0 < src1};
            alu_sll:  result = src1 << shamt;
            alu_srl:  result = src1 >> shamt;
            alu_sra:  result = $unsigned($signed(src1) >>> shamt);
            alu_lui:  result = {src1[15:0], 16'd0};
            default:  result = 32'd0;   // unused encodings
        endcase
    end

    // only the trapping forms report overflow
    always_comb begin
        case (op)
            alu_add: overflow = sum_ov;
            alu_sub: overflow = diff_ov;
            default: overflow = 1'b0;
        endcase
    end

endmodule

//--- store_align.sv
`timescale 1ns/1ns

module store_align import mips_pkg::*; (
    input  logic [31:0] rt_data,
    input  logic [1:0]  lane,
    input  store_e      store,
    output logic [31:0] wdata,
    output logic [3:0]  we
);

    // ------------------------------------------------------------
    // byte / half / word
    // ------------------------------------------------------------
    // data is replicated so the enabled lane always sees the right bytes

    // ------------------------------------------------------------
    // swl / swr, little-endian
    // ------------------------------------------------------------
    // swl at lane k: bytes 0..k get the top k+1 bytes of rt
    // swr at lane k: bytes k..3 get the low 4-k bytes of rt

    always_comb begin
        wdata = rt_data;
        we    = 4'b0000;
        case (store)
            st_b: begin
                wdata = {4{rt_data[7:0]}};
                we    = 4'b0001 << lane;
            end
            st_h: begin
                wdata = {2{rt_data[15:0]}};
                we    = lane[1] ? 4'b1100 : 4'b0011;   // lane[0] caught by addr_check
            end
            st_w: begin
                wdata = rt_data;
                we    = 4'b1111;
            end
            st_wl: begin
                case (lane)
                    2'd0: begin
                        wdata = {24'd0, rt_data[31:24]};
                        we    = 4'b0001;
                    end
                    2'd1: begin
                        wdata = {16'd0, rt_data[31:16]};
                        we    = 4'b0011;
                    end
                    2'd2: begin
                        wdata = {8'd0, rt_data[31:8]};
                        we    = 4'b0111;
                    end
                    default: begin
                        wdata = rt_data;   // lane 3, full word
                        we    = 4'b1111;
                    end
                endcase
            end
            st_wr: begin
                case (lane)
                    2'd0: begin
                        wdata = rt_data;
                        we    = 4'b1111;
                    end
                    2'd1: begin
                        wdata = {rt_data[23:0], 8'd0};
                        we    = 4'b1110;
                    end
                    2'd2: begin
                        wdata = {rt_data[15:0], 16'd0};
                        we    = 4'b1100;
                    end
                    default: begin
                        wdata = {rt_data[7:0], 24'd0};
                        we    = 4'b1000;
                    end
                endcase
            end
            default: we = 4'b0000;   // st_none, no write
        endcase
    end

endmodule

//--- addr_check.sv
`timescale 1ns/1ns

module addr_check import mips_pkg::*; (
    input  logic [1:0] addr_low,
    input  align_e     align,
    input  logic       is_load,
    output logic       exc,
    output logic [4:0] exc_code
);

    logic misaligned;

    // swl / swr and byte accesses come in as al_none
    always_comb begin
        case (align)
            al_half: misaligned = addr_low[0];
            al_word: misaligned = |addr_low;
            default: misaligned = 1'b0;
        endcase
    end

    assign exc = misaligned;

    // adel for loads, ades for stores, zero when clean
    always_comb begin
        if (!misaligned) begin
            exc_code = 5'd0;
        end else if (is_load) begin
            exc_code = exc_adel;
        end else begin
            exc_code = exc_ades;
        end
    end

endmodule

//--- exe_stage.sv
`timescale 1ns/1ns

module exe_stage import mips_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        id_valid,
    input  id_exe_t     id_in,
    output logic        exe_allowin,
    input  logic        mem_allowin,
    output logic        exe_valid,
    output exe_mem_t    exe_out,
    output logic [31:0] dm_addr,
    output logic [31:0] dm_wdata,
    output logic [3:0]  dm_we
);

    logic        valid_r;
    logic        allowin;
    id_exe_t     inst_r;

    logic [31:0] alu_res;
    logic        alu_ov;
    logic [31:0] sa_wdata;
    logic [3:0]  sa_we;
    logic        addr_exc;
    logic [4:0]  addr_code;
    logic        exc;
    logic [4:0]  exc_code;

    // ------------------------------------------------------------
    // pipeline handshake
    // ------------------------------------------------------------
    assign allowin = !valid_r || mem_allowin;   // no multicycle units in this stage

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_r <= 1'b0;
        end else if (allowin) begin
            valid_r <= id_valid;
        end
    end

    // bubble loads the all-zero word: add, st_none, al_none
    always_ff @(posedge clk) begin
        if (!rst_n || (allowin && !id_valid)) begin
            inst_r <= '0;
        end else if (allowin) begin
            inst_r <= id_in;
        end
    end

    assign exe_allowin = allowin;
    assign exe_valid   = valid_r;

    // ------------------------------------------------------------
    // datapath
    // ------------------------------------------------------------
    alu u_alu (
        .src0     (inst_r.src0),
        .src1     (inst_r.src1),
        .op       (inst_r.aluop),
        .result   (alu_res),
        .overflow (alu_ov)
    );

    store_align u_store_align (
        .rt_data (inst_r.rt_data),
        .lane    (alu_res[1:0]),
        .store   (inst_r.store),
        .wdata   (sa_wdata),
        .we      (sa_we)
    );

    addr_check u_addr_check (
        .addr_low (alu_res[1:0]),
        .align    (inst_r.align),
        .is_load  (inst_r.is_load),
        .exc      (addr_exc),
        .exc_code (addr_code)
    );

    // address error wins over overflow
    assign exc      = addr_exc || alu_ov;
    assign exc_code = addr_exc ? addr_code :
                      alu_ov   ? exc_ov    : 5'd0;

    // ------------------------------------------------------------
    // outputs
    // ------------------------------------------------------------
    always_comb begin
        exe_out.pc        = inst_r.pc;
        exe_out.nnpc      = inst_r.nnpc;
        exe_out.alu_res   = alu_res;   // address for loads / stores
        exe_out.wnum      = inst_r.wnum;
        exe_out.sel_wb    = inst_r.sel_wb;
        exe_out.load_ext  = inst_r.load_ext;
        exe_out.byte_lane = alu_res[1:0];
        exe_out.exc       = exc;
        exe_out.exc_code  = exc_code;
    end

    assign dm_addr  = alu_res;
    assign dm_wdata = sa_wdata;
    assign dm_we    = sa_we & {4{exe_valid && !exc}};   // no write from bubbles or traps

endmodule

//--- exe_stage_chk.sv
`timescale 1ns/1ns

module exe_stage_chk import mips_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       exe_valid,
    input logic       exe_allowin,
    input logic       mem_allowin,
    input exe_mem_t   exe_out,
    input logic [3:0] dm_we
);

    logic stalled;
    int   fail_cnt = 0;   // failed assertions, read back by the testbench

    assign stalled = exe_valid && !mem_allowin;   // full, memory not taking

    // ------------------------------------------------------------
    // handshake
    // ------------------------------------------------------------
    a_no_allowin_stalled: assert property (
        @(posedge clk) disable iff (!rst_n) stalled |-> !exe_allowin
    ) else begin
        fail_cnt++;
        $error("exe_allowin high while the stage is stalled");
    end

    // held instruction must not move or vanish
    a_out_stable: assert property (
        @(posedge clk) disable iff (!rst_n) stalled |=> exe_valid && $stable(exe_out)
    ) else begin
        fail_cnt++;
        $error("exe_out changed while the stage was stalled");
    end

    a_no_write_empty: assert property (
        @(posedge clk) disable iff (!rst_n) !exe_valid |-> dm_we == 4'h0
    ) else begin
        fail_cnt++;
        $error("dm_we active with an empty stage");
    end

endmodule

//--- tb_exe_stage.sv
`timescale 1ns/1ns

module tb_exe_stage import mips_pkg::*; ();

    typedef struct packed {
        exe_mem_t    out;
        logic [31:0] wdata;
        logic [3:0]  we;
    } expect_t;

    localparam int n_alu      = 14 * 29;   // 25 corner pairs + 4 random per op
    localparam int n_mem      = 20 + 8;    // store kinds x lanes, then loads
    localparam int n_rand     = 200;
    localparam int n_inst     = n_alu + n_mem + n_rand;
    localparam int max_cycles = 20 * n_inst;

    logic        clk;
    logic        rst_n;
    logic        id_valid;
    id_exe_t     id_in;
    logic        mem_allowin;
    logic        exe_allowin;
    logic        exe_valid;
    exe_mem_t    exe_out;
    logic [31:0] dm_addr;
    logic [31:0] dm_wdata;
    logic [3:0]  dm_we;

    expect_t exp_q[$];
    int      err_cnt    = 0;
    int      accept_cnt = 0;
    int      done_cnt   = 0;
    int      cycle_cnt  = 0;

    exe_stage dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .id_valid    (id_valid),
        .id_in       (id_in),
        .exe_allowin (exe_allowin),
        .mem_allowin (mem_allowin),
        .exe_valid   (exe_valid),
        .exe_out     (exe_out),
        .dm_addr     (dm_addr),
        .dm_wdata    (dm_wdata),
        .dm_we       (dm_we)
    );

    bind exe_stage exe_stage_chk u_chk (
        .clk         (clk),
        .rst_n       (rst_n),
        .exe_valid   (exe_valid),
        .exe_allowin (exe_allowin),
        .mem_allowin (mem_allowin),
        .exe_out     (exe_out),
        .dm_we       (dm_we)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    function automatic expect_t ref_model(input id_exe_t i);
        expect_t     e;
        logic [31:0] r;
        logic [32:0] wide;
        logic        ov;
        logic        mis;
        logic        en;
        int          sh;
        int          kk;
        int          src;
        e  = '0;
        sh = int'(i.src0[4:0]);
        case (i.aluop)
            alu_add, alu_addu: r = i.src0 + i.src1;
            alu_sub, alu_subu: r = i.src0 - i.src1;
            alu_and:  r = i.src0 & i.src1;
            alu_or:   r = i.src0 | i.src1;
            alu_xor:  r = i.src0 ^ i.src1;
            alu_nor:  r = ~(i.src0 | i.src1);
            alu_slt:  r = ($signed(i.src0) < $signed(i.src1)) ? 32'd1 : 32'd0;
            alu_sltu: r = (i.src0 < i.src1) ? 32'd1 : 32'd0;
            alu_sll:  r = i.src1 << sh;
            alu_srl:  r = i.src1 >> sh;
            // logical shift, then fill the vacated top bits with the sign
            alu_sra:  r = (i.src1 >> sh) | ({32{i.src1[31]}} & ~(32'hffff_ffff >> sh));
            alu_lui:  r = {i.src1[15:0], 16'h0000};
            default:  r = 32'd0;
        endcase
        // 33-bit sign-extended arithmetic, overflow when the top two bits differ
        wide = (i.aluop == alu_sub) ? {i.src0[31], i.src0} - {i.src1[31], i.src1}
                                    : {i.src0[31], i.src0} + {i.src1[31], i.src1};
        ov   = (i.aluop == alu_add || i.aluop == alu_sub) && (wide[32] != wide[31]);
        kk   = int'(r[1:0]);
        mis  = (i.align == al_half && r[0]) || (i.align == al_word && r[1:0] != 2'b00);

        e.out.pc        = i.pc;
        e.out.nnpc      = i.nnpc;
        e.out.alu_res   = r;
        e.out.wnum      = i.wnum;
        e.out.sel_wb    = i.sel_wb;
        e.out.load_ext  = i.load_ext;
        e.out.byte_lane = r[1:0];
        e.out.exc       = mis || ov;
        e.out.exc_code  = mis ? (i.is_load ? exc_adel : exc_ades) : (ov ? exc_ov : 5'd0);

        // per memory byte: is it written, and which rt_data byte lands there
        for (int b = 0; b < 4; b++) begin
            case (i.store)
                st_b:    en = (b == kk);
                st_h:    en = (b / 2 == kk / 2);
                st_w:    en = 1'b1;
                st_wl:   en = (b <= kk);
                st_wr:   en = (b >= kk);
                default: en = 1'b0;
            endcase
            case (i.store)
                st_b:    src = 0;
                st_h:    src = b % 2;
                st_wl:   src = b + 3 - kk;   // top kk+1 bytes
                st_wr:   src = b - kk;       // low 4-kk bytes
                default: src = b;
            endcase
            if (en && !e.out.exc) begin
                e.we[b]           = 1'b1;
                e.wdata[8*b +: 8] = i.rt_data[8*src +: 8];
            end
        end
        return e;
    endfunction

    function automatic id_exe_t make_inst(input alu_op_e op, input logic [31:0] a,
                                          input logic [31:0] b, input store_e st,
                                          input align_e al, input logic ld);
        id_exe_t i;
        i          = '0;
        i.pc       = $urandom & 32'hffff_fffc;
        i.nnpc     = i.pc + 32'd8;
        i.src0     = a;
        i.src1     = b;
        i.rt_data  = $urandom;
        i.aluop    = op;
        i.store    = st;
        i.align    = al;
        i.is_load  = ld;
        i.wnum     = 5'($urandom);
        i.sel_wb   = 5'($urandom);
        i.load_ext = 5'($urandom);
        return i;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            err_cnt++;
            $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    // hold one instruction on the decode side until the stage takes it
    task automatic send(input id_exe_t inst);
        int target;
        target   = accept_cnt + 1;
        id_in    = inst;
        id_valid = 1'b1;
        while (accept_cnt < target) begin
            @(negedge clk);
        end
        id_valid = 1'b0;
        repeat ($urandom_range(0, 2)) @(negedge clk);   // idle gap, bubbles enter
    endtask

    // ------------------------------------------------------------
    // scoreboard and compare
    // ------------------------------------------------------------
    always @(posedge clk) begin
        expect_t     e;
        logic [31:0] mask;
        if (rst_n && exe_valid && mem_allowin) begin
            assert (exp_q.size() != 0) else begin
                err_cnt++;
                $display("stage delivered an instruction that was never accepted");
            end
            if (exp_q.size() != 0) begin
                e    = exp_q.pop_front();
                mask = {{8{e.we[3]}}, {8{e.we[2]}}, {8{e.we[1]}}, {8{e.we[0]}}};
                done_cnt++;
                check_val("exe_out.pc", exe_out.pc, e.out.pc);
                check_val("exe_out.nnpc", exe_out.nnpc, e.out.nnpc);
                check_val("exe_out.alu_res", exe_out.alu_res, e.out.alu_res);
                check_val("exe_out.wnum", exe_out.wnum, e.out.wnum);
                check_val("exe_out.sel_wb", exe_out.sel_wb, e.out.sel_wb);
                check_val("exe_out.load_ext", exe_out.load_ext, e.out.load_ext);
                check_val("exe_out.byte_lane", exe_out.byte_lane, e.out.byte_lane);
                check_val("exe_out.exc", exe_out.exc, e.out.exc);
                check_val("exe_out.exc_code", exe_out.exc_code, e.out.exc_code);
                check_val("dm_addr", dm_addr, e.out.alu_res);
                check_val("dm_we", dm_we, e.we);
                check_val("dm_wdata", dm_wdata & mask, e.wdata & mask);   // enabled bytes only
            end
        end
        if (rst_n && id_valid && exe_allowin) begin
            exp_q.push_back(ref_model(id_in));
            accept_cnt++;
        end
    end

    // memory stage back-pressure
    always @(negedge clk) begin
        if (!rst_n) begin
            mem_allowin = 1'b1;
        end else begin
            mem_allowin = ($urandom_range(0, 2) != 0);
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > max_cycles + 8) begin
            $display("timeout after %0d cycles, %0d of %0d instructions delivered",
                     cycle_cnt, done_cnt, n_inst);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    initial begin
        logic [31:0] corner [5];
        alu_op_e     op;
        store_e      st;
        align_e      al;
        corner      = '{32'h0000_0000, 32'h0000_0001, 32'h7fff_ffff, 32'h8000_0000,
                        32'hffff_ffff};
        void'($urandom(32'h0927_4d9e));
        rst_n       = 1'b0;
        id_valid    = 1'b0;
        id_in       = '0;
        mem_allowin = 1'b1;
        repeat (8) @(negedge clk);
        check_val("exe_valid", exe_valid, 1'b0);
        check_val("exe_allowin", exe_allowin, 1'b1);
        check_val("dm_we", dm_we, 4'h0);
        rst_n = 1'b1;

        for (int o = 0; o < 14; o++) begin
            op = alu_op_e'(o);
            foreach (corner[x]) begin
                foreach (corner[y]) begin
                    send(make_inst(op, corner[x], corner[y], st_none, al_none, 1'b0));
                end
            end
            repeat (4) send(make_inst(op, $urandom, $urandom, st_none, al_none, 1'b0));
        end

        // stores at every lane, misaligned sh / sw included
        for (int s = 1; s < 6; s++) begin
            st = store_e'(s);
            al = (st == st_h) ? al_half : ((st == st_w) ? al_word : al_none);
            for (int k = 0; k < 4; k++) begin
                send(make_inst(alu_addu, $urandom & 32'hffff_fffc, k, st, al, 1'b0));
            end
        end
        for (int k = 0; k < 8; k++) begin
            al = (k < 4) ? al_half : al_word;
            send(make_inst(alu_addu, $urandom & 32'hffff_fffc, k % 4, st_none, al, 1'b1));
        end

        repeat (n_rand) begin
            op = alu_op_e'($urandom_range(0, 13));
            st = store_e'($urandom_range(0, 5));
            al = align_e'($urandom_range(0, 2));
            send(make_inst(op, $urandom, $urandom, st, al, 1'($urandom)));
        end

        while (exp_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
        // drained, only bubbles left in the stage
        check_val("exe_valid", exe_valid, 1'b0);
        check_val("exe_allowin", exe_allowin, 1'b1);
        err_cnt += dut0.u_chk.fail_cnt;
        $display("summary: %0d errors, %0d instructions accepted, %0d checked",
                 err_cnt, accept_cnt, done_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
mips_pkg.sv
alu.sv
store_align.sv
addr_check.sv
exe_stage.sv
exe_stage_chk.sv
tb_exe_stage.sv

//--- run.sh
#!/bin/bash
# build and run the exe_stage testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_exe_stage \
    -f list.f -Mdir obj_dir > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vtb_exe_stage > sim.log 2>&1
cat sim.log

grep -qx "TESTBENCH PASSED" sim.log && exit 0 || exit 1
